// ==== Bender.yml ====
package:
  name: cq_rx

sources:
  - files:
      - rtl/cq_rx_pkg.sv
      - rtl/cq_rx_ctrl.sv
      - rtl/cq_desc_parser.sv
      - rtl/tlp_hdr_builder.sv
      - rtl/cpl_field_calc.sv
      - rtl/req_out_buf.sv
      - rtl/cq_rx_top.sv
  - target: simulation
    files:
      - tests/tb_cq_rx.sv

// ==== rtl/cpl_field_calc.sv ====
// Completion field calculation
// Byte count and lower address for memory reads
`timescale 1ns/10ps

module cpl_field_calc (
  input  logic                user_clk,
  input  logic                user_reset_n,
  input  cq_rx_pkg::cq_desc_t desc,
  input  logic                desc_vld,
  output cq_rx_pkg::cpl_req_t cpl,
  output logic                cpl_push
);

  import cq_rx_pkg::*;

  // Zero bits below the lowest set bit, all bits when empty
  function automatic logic [2:0] zeros_below(input logic [BE_W-1:0] be);
    logic [2:0] n;
    n = 3'(BE_W);
    for (int i = BE_W - 1; i >= 0; i--) begin
      if (be[i]) begin
        n = 3'(i);
      end
    end
    return n;
  endfunction

  // Zero bits above the highest set bit, all bits when empty
  function automatic logic [2:0] zeros_above(input logic [BE_W-1:0] be);
    logic [2:0] n;
    n = 3'(BE_W);
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) begin
        n = 3'(BE_W - 1 - i);
      end
    end
    return n;
  endfunction

  logic [2:0]  fbe_lo_zeros;
  logic [2:0]  fbe_hi_zeros;
  logic [2:0]  lbe_hi_zeros;
  logic [2:0]  single_bytes;
  logic [12:0] multi_bytes;
  logic [11:0] byte_count;
  logic [1:0]  byte_off;
  logic [6:0]  lower_addr;
  logic        is_read;

  assign fbe_lo_zeros = zeros_below(desc.first_be);
  assign fbe_hi_zeros = zeros_above(desc.first_be);
  assign lbe_hi_zeros = zeros_above(desc.last_be);

  ////////////////////////////////////////////////////////////
  // Byte count
  ////////////////////////////////////////////////////////////
  assign single_bytes = 3'(BE_W) - fbe_lo_zeros - fbe_hi_zeros;  // Span of first_be
  assign multi_bytes  = {desc.dw_len, 2'b00} - 13'(fbe_lo_zeros) - 13'(lbe_hi_zeros);

  always_comb begin
    if (desc.last_be == '0) begin
      byte_count = (desc.first_be == '0) ? 12'd1 : 12'(single_bytes);
    end else begin
      byte_count = multi_bytes[11:0];  // 1024 DW wraps to zero
    end
  end

  // Lower address from dword address and first enabled byte
  assign byte_off   = (desc.first_be == '0) ? 2'b00 : fbe_lo_zeros[1:0];
  assign lower_addr = (desc.dw_len == '0) ? 7'h0 : {desc.addr[6:2], byte_off};

  assign is_read = desc_vld && (desc.req_type == MEM_RD);

  always_ff @(posedge user_clk or negedge user_reset_n) begin
    if (!user_reset_n) begin
      cpl_push <= 1'b0;
    end else begin
      cpl_push <= is_read;
    end
  end

  always_ff @(posedge user_clk) begin
    if (is_read) begin
      cpl.requester_id <= desc.requester_id;
      cpl.tag          <= desc.tag;
      cpl.tc           <= desc.tc;
      cpl.attr         <= desc.attr;
      cpl.dw_len       <= desc.dw_len;
      cpl.byte_count   <= byte_count;
      cpl.lower_addr   <= lower_addr;
    end
  end

endmodule

// ==== rtl/cq_desc_parser.sv ====
// CQ descriptor capture
`timescale 1ns/10ps

module cq_desc_parser (
  input  logic                           user_clk,
  input  logic                           user_reset_n,
  input  logic                           desc_take,
  input  logic [cq_rx_pkg::CQ_DATA_W-1:0] cq_data,
  input  logic [cq_rx_pkg::BE_W-1:0]      cq_first_be,
  input  logic [cq_rx_pkg::BE_W-1:0]      cq_last_be,
  output cq_rx_pkg::cq_desc_t             desc,
  output logic                           desc_vld
);

  import cq_rx_pkg::*;

  always_ff @(posedge user_clk or negedge user_reset_n) begin
    if (!user_reset_n) begin
      desc_vld <= 1'b0;
    end else begin
      desc_vld <= desc_take;  // One pulse per capture
    end
  end

  ////////////////////////////////////////////////////////////
  // Field slicing from the header beat
  ////////////////////////////////////////////////////////////
  always_ff @(posedge user_clk) begin
    if (desc_take) begin
      desc.addr         <= cq_data[63:0];
      desc.dw_len       <= cq_data[74:64];
      desc.req_type     <= req_type_e'(cq_data[78:75]);
      desc.requester_id <= cq_data[95:80];
      desc.tag          <= cq_data[103:96];
      desc.msg_code     <= cq_data[111:104];
      desc.msg_route    <= cq_data[114:112];
      desc.tc           <= cq_data[123:121];
      desc.attr         <= cq_data[126:124];  // ID order, relaxed, no snoop
      desc.first_be     <= cq_first_be;
      desc.last_be      <= cq_last_be;
      desc.low_dw       <= cq_data[63:0];     // Same dwords, kept as message body
    end
  end

endmodule

// ==== rtl/cq_rx_ctrl.sv ====
// CQ link and frame control
`timescale 1ns/10ps

module cq_rx_ctrl #(
  parameter int CNT_W = 3
) (
  input  logic             user_clk,
  input  logic             user_reset_n,
  input  logic             link_up,
  input  logic             cq_valid,
  input  logic             cq_sop,
  input  logic             cq_last,
  input  logic [CNT_W-1:0] hdr_free,
  input  logic [CNT_W-1:0] cpl_free,
  output logic             cq_ready,
  output logic             desc_take
);

  // Two requests may sit in parser and builder, plus the one on the bus
  localparam int MIN_FREE = 3;

  typedef enum logic [1:0] {
    LINK_DOWN = 2'b00,
    IDLE      = 2'b01,
    IN_FRAME  = 2'b10
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   room;
  logic   beat_acc;

  assign room      = (hdr_free >= CNT_W'(MIN_FREE)) && (cpl_free >= CNT_W'(MIN_FREE));
  assign cq_ready  = (state != LINK_DOWN) && room;
  assign beat_acc  = cq_valid && cq_ready;
  assign desc_take = beat_acc && cq_sop && (state == IDLE);  // Header beat only

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      LINK_DOWN: begin
        if (link_up) begin
          state_nxt = IDLE;
        end
      end
      IDLE: begin
        if (!link_up) begin
          state_nxt = LINK_DOWN;
        end else if (beat_acc && cq_sop && !cq_last) begin
          state_nxt = IN_FRAME;  // Payload follows
        end
      end
      IN_FRAME: begin
        if (!link_up) begin
          state_nxt = LINK_DOWN;  // Rest of frame is dropped
        end else if (beat_acc && cq_last) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = LINK_DOWN;
      end
    endcase
  end

  always_ff @(posedge user_clk or negedge user_reset_n) begin
    if (!user_reset_n) begin
      state <= LINK_DOWN;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

// ==== rtl/cq_rx_pkg.sv ====
// CQ receive shared types
// Widths, request encodings and packed structs

package cq_rx_pkg;

  localparam int CQ_DATA_W = 128;  // Beat width
  localparam int BE_W      = 4;    // Byte enables per dword

  ////////////////////////////////////////////////////////////
  // Request types from the CQ descriptor
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    MEM_RD  = 4'b0000,
    MEM_WR  = 4'b0001,
    MSG     = 4'b1100,
    VDM     = 4'b1101,
    ATS_MSG = 4'b1110
  } req_type_e;

  // TLP Fmt and Type codes
  localparam logic [2:0] FMT_3DW_ND = 3'b000;  // 3DW header, no data
  localparam logic [2:0] FMT_4DW_ND = 3'b001;  // 4DW header, no data
  localparam logic [2:0] FMT_3DW_D  = 3'b010;  // 3DW header with data
  localparam logic [2:0] FMT_4DW_D  = 3'b011;  // 4DW header with data
  localparam logic [4:0] TYPE_MEM   = 5'b00000;
  localparam logic [1:0] TYPE_MSG   = 2'b10;   // Followed by routing

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [CQ_DATA_W-1:0] data;
    logic                 sop;
    logic                 last;
    logic [BE_W-1:0]      first_be;
    logic [BE_W-1:0]      last_be;
  } cq_beat_t;

  typedef struct packed {
    logic [63:0]     addr;
    logic [10:0]     dw_len;
    req_type_e       req_type;
    logic [15:0]     requester_id;
    logic [7:0]      tag;
    logic [7:0]      msg_code;
    logic [2:0]      msg_route;
    logic [2:0]      tc;
    logic [2:0]      attr;
    logic [BE_W-1:0] first_be;
    logic [BE_W-1:0] last_be;
    logic [63:0]     low_dw;        // Message body for messages
  } cq_desc_t;

  typedef struct packed {
    logic [31:0] hdr_dw0;
    logic [31:0] hdr_dw1;
    logic [31:0] hdr_dw2;
    logic [31:0] hdr_dw3;
  } tlp_hdr_t;

  typedef struct packed {
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [2:0]  tc;
    logic [2:0]  attr;
    logic [10:0] dw_len;
    logic [11:0] byte_count;
    logic [6:0]  lower_addr;
  } cpl_req_t;

endpackage

// ==== rtl/cq_rx_top.sv ====
// CQ receive top level
`timescale 1ns/10ps

module cq_rx_top #(
  parameter int OUT_DEPTH = 4
) (
  input  logic                user_clk,
  input  logic                user_reset_n,
  input  logic                link_up,
  input  cq_rx_pkg::cq_beat_t cq_beat,
  input  logic                cq_valid,
  output logic                cq_ready,
  output cq_rx_pkg::tlp_hdr_t hdr_out,
  output logic                hdr_valid,
  input  logic                hdr_ready,
  output cq_rx_pkg::cpl_req_t cpl_out,
  output logic                cpl_valid,
  input  logic                cpl_ready
);

  import cq_rx_pkg::*;

  localparam int CNT_W = $clog2(OUT_DEPTH + 1);

  logic             desc_take;
  cq_desc_t         desc;
  logic             desc_vld;
  tlp_hdr_t         hdr;
  logic             hdr_push;
  cpl_req_t         cpl;
  logic             cpl_push;
  logic [CNT_W-1:0] hdr_free;
  logic [CNT_W-1:0] cpl_free;

  ////////////////////////////////////////////////////////////
  // Control and descriptor capture
  ////////////////////////////////////////////////////////////
  cq_rx_ctrl #(
    .CNT_W (CNT_W)
  ) u_ctrl (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .link_up      (link_up),
    .cq_valid     (cq_valid),
    .cq_sop       (cq_beat.sop),
    .cq_last      (cq_beat.last),
    .hdr_free     (hdr_free),
    .cpl_free     (cpl_free),
    .cq_ready     (cq_ready),
    .desc_take    (desc_take)
  );

  cq_desc_parser u_parser (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .desc_take    (desc_take),
    .cq_data      (cq_beat.data),
    .cq_first_be  (cq_beat.first_be),
    .cq_last_be   (cq_beat.last_be),
    .desc         (desc),
    .desc_vld     (desc_vld)
  );

  ////////////////////////////////////////////////////////////
  // Header and completion paths
  ////////////////////////////////////////////////////////////
  tlp_hdr_builder u_hdr (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .desc         (desc),
    .desc_vld     (desc_vld),
    .hdr          (hdr),
    .hdr_push     (hdr_push)
  );

  cpl_field_calc u_cpl (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .desc         (desc),
    .desc_vld     (desc_vld),
    .cpl          (cpl),
    .cpl_push     (cpl_push)
  );

  req_out_buf #(
    .payload_t (tlp_hdr_t),
    .DEPTH     (OUT_DEPTH),
    .CNT_W     (CNT_W)
  ) u_hdr_buf (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .push         (hdr_push),
    .push_data    (hdr),
    .out_data     (hdr_out),
    .out_valid    (hdr_valid),
    .out_ready    (hdr_ready),
    .free_slots   (hdr_free)
  );

  req_out_buf #(
    .payload_t (cpl_req_t),
    .DEPTH     (OUT_DEPTH),
    .CNT_W     (CNT_W)
  ) u_cpl_buf (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .push         (cpl_push),
    .push_data    (cpl),
    .out_data     (cpl_out),
    .out_valid    (cpl_valid),
    .out_ready    (cpl_ready),
    .free_slots   (cpl_free)
  );

endmodule

// ==== rtl/req_out_buf.sv ====
// Output request FIFO
`timescale 1ns/10ps

module req_out_buf #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4,
  parameter int  CNT_W     = 3
) (
  input  logic             user_clk,
  input  logic             user_reset_n,
  input  logic             push,
  input  payload_t         push_data,
  output payload_t         out_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [CNT_W-1:0] free_slots
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  assign out_valid  = (count != '0);
  assign out_data   = mem[rd_ptr];  // Holds while stalled
  assign free_slots = CNT_W'(DEPTH) - count;
  assign rd_en      = out_valid && out_ready;
  assign wr_en      = push && (count != CNT_W'(DEPTH));

  always_ff @(posedge user_clk or negedge user_reset_n) begin
    if (!user_reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
      if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
      count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
    end
  end

  always_ff @(posedge user_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

// ==== rtl/tlp_hdr_builder.sv ====
// TLP header builder
// Rebuilds a 4DW PCIe header from a CQ descriptor
`timescale 1ns/10ps

module tlp_hdr_builder (
  input  logic                user_clk,
  input  logic                user_reset_n,
  input  cq_rx_pkg::cq_desc_t desc,
  input  logic                desc_vld,
  output cq_rx_pkg::tlp_hdr_t hdr,
  output logic                hdr_push
);

  import cq_rx_pkg::*;

  logic        addr64;
  logic        kept;
  logic [2:0]  fmt;
  logic [4:0]  typ;
  logic [23:0] dw0_low;
  tlp_hdr_t    hdr_nxt;

  assign addr64 = (desc.addr[63:32] != 32'h0);

  // TC, attributes and length, common to every kept type
  assign dw0_low = {1'b0, desc.tc, 1'b0, desc.attr[2], 2'b00,
                    1'b0, 1'b0, desc.attr[1:0], 2'b00, desc.dw_len[9:0]};

  ////////////////////////////////////////////////////////////
  // Header per request type
  ////////////////////////////////////////////////////////////
  always_comb begin
    kept    = 1'b1;
    fmt     = FMT_4DW_ND;
    typ     = TYPE_MEM;
    hdr_nxt = '0;
    case (desc.req_type)
      MEM_RD, MEM_WR: begin
        if (desc.req_type == MEM_RD) begin
          fmt = addr64 ? FMT_4DW_ND : FMT_3DW_ND;
        end else begin
          fmt = addr64 ? FMT_4DW_D : FMT_3DW_D;
        end
        hdr_nxt.hdr_dw1 = {desc.requester_id, desc.tag, desc.last_be, desc.first_be};
        if (addr64) begin
          hdr_nxt.hdr_dw2 = desc.addr[63:32];
          hdr_nxt.hdr_dw3 = {desc.addr[31:2], 2'b00};
        end else begin
          hdr_nxt.hdr_dw2 = {desc.addr[31:2], 2'b00};
          hdr_nxt.hdr_dw3 = 32'h0;
        end
      end
      MSG, VDM, ATS_MSG: begin
        typ             = {TYPE_MSG, desc.msg_route};
        hdr_nxt.hdr_dw1 = {desc.requester_id, desc.tag, desc.msg_code};
        hdr_nxt.hdr_dw2 = desc.low_dw[63:32];
        hdr_nxt.hdr_dw3 = desc.low_dw[31:0];
      end
      default: begin
        kept = 1'b0;  // Unsupported, no output
      end
    endcase
    hdr_nxt.hdr_dw0 = {fmt, typ, dw0_low};
  end

  always_ff @(posedge user_clk or negedge user_reset_n) begin
    if (!user_reset_n) begin
      hdr_push <= 1'b0;
    end else begin
      hdr_push <= desc_vld && kept;
    end
  end

  always_ff @(posedge user_clk) begin
    if (desc_vld && kept) begin
      hdr <= hdr_nxt;
    end
  end

endmodule

// ==== src.f ====
rtl/cq_rx_pkg.sv
rtl/cq_rx_ctrl.sv
rtl/cq_desc_parser.sv
rtl/tlp_hdr_builder.sv
rtl/cpl_field_calc.sv
rtl/req_out_buf.sv
rtl/cq_rx_top.sv
tests/tb_cq_rx.sv

// ==== tests/tb_cq_rx.sv ====
// CQ receive testbench
`timescale 1ns/10ps

module tb_cq_rx;

  import cq_rx_pkg::*;

  localparam int N_REQ     = 106;              // Requests over all tests
  localparam int CYC_LIMIT = 40 * N_REQ + 200;

  logic     user_clk;
  logic     user_reset_n;
  logic     link_up;
  cq_beat_t cq_beat;
  logic     cq_valid;
  logic     cq_ready;
  tlp_hdr_t hdr_out;
  logic     hdr_valid;
  logic     hdr_ready;
  cpl_req_t cpl_out;
  logic     cpl_valid;
  logic     cpl_ready;

  tlp_hdr_t exp_hdr_q[$];
  cpl_req_t exp_cpl_q[$];
  tlp_hdr_t exp_hdr;
  cpl_req_t exp_cpl;
  int       cycle_cnt;
  int       err_count;
  int       test_err_base;
  int       check_count;
  int       tests_done;
  logic     stall_watch;
  logic     saw_drop;
  logic     burst_done;

  cq_rx_top #(
    .OUT_DEPTH (4)
  ) uut (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .link_up      (link_up),
    .cq_beat      (cq_beat),
    .cq_valid     (cq_valid),
    .cq_ready     (cq_ready),
    .hdr_out      (hdr_out),
    .hdr_valid    (hdr_valid),
    .hdr_ready    (hdr_ready),
    .cpl_out      (cpl_out),
    .cpl_valid    (cpl_valid),
    .cpl_ready    (cpl_ready)
  );

  initial begin
    user_clk = 1'b0;
    forever #10 user_clk = ~user_clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic tlp_hdr_t ref_tlp_hdr(input cq_desc_t r);
    tlp_hdr_t h;
    logic     wide;
    h    = '0;
    wide = (r.addr[63:32] != 32'h0);
    h.hdr_dw0[22:20] = r.tc;
    h.hdr_dw0[18]    = r.attr[2];        // ID-based ordering
    h.hdr_dw0[13:12] = r.attr[1:0];
    h.hdr_dw0[9:0]   = r.dw_len[9:0];
    if (r.req_type inside {MSG, VDM, ATS_MSG}) begin
      h.hdr_dw0[31:29] = 3'b001;
      h.hdr_dw0[28:24] = {2'b10, r.msg_route};
      h.hdr_dw1        = {r.requester_id, r.tag, r.msg_code};
      h.hdr_dw2        = r.addr[63:32];  // Message body
      h.hdr_dw3        = r.addr[31:0];
    end else begin
      h.hdr_dw0[31:29] = {1'b0, r.req_type == MEM_WR, wide};
      h.hdr_dw1        = {r.requester_id, r.tag, r.last_be, r.first_be};
      if (wide) begin
        h.hdr_dw2 = r.addr[63:32];
        h.hdr_dw3 = {r.addr[31:2], 2'b00};
      end else begin
        h.hdr_dw2 = {r.addr[31:2], 2'b00};
      end
    end
    return h;
  endfunction

  function automatic cpl_req_t ref_cpl(input cq_desc_t r);
    cpl_req_t c;
    int       lo_f;
    int       hi_f;
    int       hi_l;
    int       bytes;
    lo_f = -1;
    hi_f = -1;
    hi_l = -1;
    for (int i = 0; i < 4; i++) begin
      if (r.first_be[i] && lo_f < 0) lo_f = i;
      if (r.first_be[i]) hi_f = i;
      if (r.last_be[i]) hi_l = i;
    end
    c              = '0;
    c.requester_id = r.requester_id;
    c.tag          = r.tag;
    c.tc           = r.tc;
    c.attr         = r.attr;
    c.dw_len       = r.dw_len;
    if (r.last_be == 4'h0) begin
      bytes = (lo_f < 0) ? 1 : hi_f - lo_f + 1;   // Single dword
    end else begin
      bytes = r.dw_len * 4 - ((lo_f < 0) ? 4 : lo_f) - (3 - hi_l);
    end
    c.byte_count = 12'(bytes);
    if (r.dw_len != 11'd0) begin
      c.lower_addr = {r.addr[6:2], (lo_f < 0) ? 2'b00 : 2'(lo_f)};
    end
    return c;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  function automatic cq_desc_t rand_req(input logic [3:0] typ);
    cq_desc_t r;
    r              = '0;
    r.req_type     = req_type_e'(typ);
    r.requester_id = 16'($urandom);
    r.tag          = 8'($urandom);
    r.msg_code     = 8'($urandom);
    r.msg_route    = 3'($urandom);
    r.tc           = 3'($urandom);
    r.attr         = 3'($urandom);
    r.addr         = {($urandom % 2) ? 32'($urandom) : 32'h0, 32'($urandom)};
    r.dw_len       = ($urandom % 3 == 0) ? 11'd1 : 11'(1 + $urandom % 64);
    if (r.dw_len == 11'd1) begin
      r.first_be = 4'($urandom);
    end else begin
      r.first_be = 4'(1 + $urandom % 15);
      r.last_be  = 4'(1 + $urandom % 15);
    end
    r.low_dw = r.addr;
    return r;
  endfunction

  function automatic cq_beat_t pack_beat(input cq_desc_t r, input logic last);
    cq_beat_t b;
    b               = '0;
    b.data[63:0]    = r.addr;
    b.data[74:64]   = r.dw_len;
    b.data[78:75]   = r.req_type;
    b.data[79]      = 1'($urandom);  // Reserved, noise only
    b.data[95:80]   = r.requester_id;
    b.data[103:96]  = r.tag;
    b.data[111:104] = r.msg_code;
    b.data[114:112] = r.msg_route;
    b.data[120:115] = 6'($urandom);
    b.data[123:121] = r.tc;
    b.data[126:124] = r.attr;
    b.data[127]     = 1'($urandom);
    b.sop           = 1'b1;
    b.last          = last;
    b.first_be      = r.first_be;
    b.last_be       = r.last_be;
    return b;
  endfunction

  task automatic wait_accept();
    do begin
      @(posedge user_clk);
    end while (!cq_ready);
  endtask

  // Header beat, then n_pay payload beats, expected items queued on acceptance
  task automatic send_req(input cq_desc_t r, input int n_pay);
    cq_beat_t b;
    b        = pack_beat(r, n_pay == 0);
    cq_beat  = b;
    cq_valid = 1'b1;
    wait_accept();
    if (r.req_type inside {MEM_RD, MEM_WR, MSG, VDM, ATS_MSG}) begin
      exp_hdr_q.push_back(ref_tlp_hdr(r));
    end
    if (r.req_type == MEM_RD) begin
      exp_cpl_q.push_back(ref_cpl(r));
    end
    for (int i = 1; i <= n_pay; i++) begin
      #2;
      b.data  = {$urandom, $urandom, $urandom, $urandom};
      b.sop   = 1'b0;
      b.last  = (i == n_pay);
      cq_beat = b;
      wait_accept();
    end
    #2;
    cq_valid = 1'b0;
    cq_beat  = '0;
  endtask

  task automatic drain_outputs();
    while (exp_hdr_q.size() != 0 || exp_cpl_q.size() != 0) begin
      @(posedge user_clk);
    end
    repeat (6) @(posedge user_clk);  // Room for stray outputs
    #2;
  endtask

  task automatic finish_test(input string name);
    $display("%-14s %0d errors", name, err_count - test_err_base);
    test_err_base = err_count;
    tests_done++;
  endtask

  task automatic stall_outputs();
    int pick;
    int len;
    while (!burst_done) begin
      pick      = $urandom % 3;
      len       = 1 + $urandom % 20;
      hdr_ready = (pick == 1);  // 0 stalls hdr, 1 stalls cpl, 2 both
      cpl_ready = (pick == 0);
      repeat (len) @(posedge user_clk);
      #2;
      hdr_ready = 1'b1;
      cpl_ready = 1'b1;
      len       = 1 + $urandom % 6;
      repeat (len) @(posedge user_clk);
      #2;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Comparing process
  ////////////////////////////////////////////////////////////
  always @(posedge user_clk) begin
    cycle_cnt++;
    if (stall_watch && cq_valid && !cq_ready && (!hdr_ready || !cpl_ready)) saw_drop = 1'b1;
    if (hdr_valid && hdr_ready) begin
      assert (exp_hdr_q.size() != 0) else begin
        $display("A header came out with no request pending");
        err_count++;
      end
      if (exp_hdr_q.size() != 0) begin
        exp_hdr = exp_hdr_q.pop_front();
        check_count++;
        assert (hdr_out == exp_hdr) else begin
          $display("ERR hdr_out got %h expected %h", hdr_out, exp_hdr);
          err_count++;
        end
      end
    end
    if (cpl_valid && cpl_ready) begin
      assert (exp_cpl_q.size() != 0) else begin
        $display("A completion record came out with no read pending");
        err_count++;
      end
      if (exp_cpl_q.size() != 0) begin
        exp_cpl = exp_cpl_q.pop_front();
        check_count++;
        assert (cpl_out == exp_cpl) else begin
          $display("ERR cpl_out got %h expected %h", cpl_out, exp_cpl);
          err_count++;
        end
      end
    end
  end

  initial begin
    wait (cycle_cnt >= CYC_LIMIT);
    $display("Run stopped after %0d cycles with requests still pending", cycle_cnt);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  task automatic link_gating_test();
    int n;
    repeat (4) begin
      @(posedge user_clk);
      assert (!cq_ready) else begin
        $display("cq_ready was high while the link was down");
        err_count++;
      end
    end
    #2;
    link_up = 1'b1;
    n       = 0;
    do begin
      @(posedge user_clk);
      n++;
    end while (!cq_ready);
    assert (n == 2) else begin
      $display("ERR cq_ready rise delay got %h expected %h", n, 2);
      err_count++;
    end
    #2;
    send_req(rand_req(MEM_RD), 0);
    n = 0;
    do begin
      @(posedge user_clk);
      n++;
    end while (!cpl_valid);
    assert (n == 3) else begin
      $display("ERR cpl_valid latency got %h expected %h", n, 3);
      err_count++;
    end
    #2;
    link_up = 1'b0;
    repeat (2) @(posedge user_clk);
    assert (!cq_ready) else begin
      $display("cq_ready stayed high after the link went down");
      err_count++;
    end
    #2;
    link_up = 1'b1;
    drain_outputs();
    finish_test("link_gating");
  endtask

  task automatic write_test();
    for (int i = 0; i < 12; i++) begin
      send_req(rand_req(MEM_WR), 1 + i % 6);
      send_req(rand_req(MEM_RD), 0);       // Parsed right after the frame
    end
    drain_outputs();
    finish_test("writes");
  endtask

  task automatic msg_test();
    logic [3:0] typ;
    for (int i = 0; i < 6; i++) begin
      typ = (i % 3 == 0) ? MSG : (i % 3 == 1) ? VDM : ATS_MSG;
      send_req(rand_req(typ), 0);
    end
    send_req(rand_req(4'b0010), 0);  // Unsupported types
    send_req(rand_req(4'b1111), 1);
    send_req(rand_req(MEM_RD), 0);
    drain_outputs();
    finish_test("messages");
  endtask

  task automatic zero_len_test();
    cq_desc_t r;
    r          = rand_req(MEM_RD);
    r.dw_len   = '0;
    r.first_be = '0;
    r.last_be  = '0;
    send_req(r, 0);
    r          = rand_req(MEM_RD);
    r.dw_len   = '0;
    r.first_be = 4'b0110;
    r.last_be  = '0;
    send_req(r, 0);
    drain_outputs();
    finish_test("zero_length");
  endtask

  task automatic backpressure_test();
    int pick;
    burst_done  = 1'b0;
    saw_drop    = 1'b0;
    stall_watch = 1'b1;
    fork
      begin
        for (int i = 0; i < 30; i++) begin
          pick = $urandom % 3;
          if (pick == 0) send_req(rand_req(MEM_RD), 0);
          else if (pick == 1) send_req(rand_req(MEM_WR), 1 + $urandom % 2);
          else send_req(rand_req(VDM), 0);
        end
        burst_done = 1'b1;
      end
      stall_outputs();
    join
    stall_watch = 1'b0;
    drain_outputs();
    assert (saw_drop) else begin
      $display("cq_ready never fell while the outputs were stalled");
      err_count++;
    end
    finish_test("backpressure");
  endtask

  initial begin
    void'($urandom(32'hb443_e4e3));
    user_reset_n = 1'b0;
    link_up      = 1'b0;
    cq_beat      = '0;
    cq_valid     = 1'b0;
    hdr_ready    = 1'b1;
    cpl_ready    = 1'b1;
    stall_watch  = 1'b0;
    saw_drop     = 1'b0;
    burst_done   = 1'b0;
    repeat (3) @(posedge user_clk);
    #2;
    user_reset_n = 1'b1;
    link_gating_test();
    for (int i = 0; i < 40; i++) begin
      send_req(rand_req(MEM_RD), 0);
    end
    drain_outputs();
    finish_test("reads");
    write_test();
    msg_test();
    zero_len_test();
    backpressure_test();
    $display("%0d tests, %0d checks, %0d errors", tests_done, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
